//--- verilog.f
avr_pkg.sv
alu.sv
io_space.sv
reg_file.sv
sequencer.sv
avr_core.sv
tb_avr_core.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_avr_core -f verilog.f

./obj_dir/Vtb_avr_core

//--- tb_avr_core.sv
module tb_avr_core;

    timeunit 1ns;
    timeprecision 1ps;

    import avr_pkg::*;

    localparam int PROG_LEN = 400;
    localparam int RAND_END = 300;        // Random code lives below this address
    localparam int END_PC   = PROG_LEN - 1;
    localparam int MAX_RUN  = 150000;

    localparam logic [5:0] RR_CODES [10] = '{6'b000011, 6'b000111, 6'b000110, 6'b000010,
        6'b001000, 6'b001010, 6'b001001, 6'b000101, 6'b000001, 6'b001011};
    localparam logic [3:0] ONE_CODES [8] = '{4'h0, 4'h1, 4'h2, 4'h3, 4'h5, 4'h6, 4'h7, 4'hA};
    localparam io_addr_t IN_ADDRS [7] = '{IO_BANK, IO_KB_DATA, IO_KB_STAT, IO_CURSOR_X,
        IO_SREG, IO_TIMER_LO, 6'h01};

    logic  clock;
    logic  rst_n;
    word_t pc;
    word_t ir;
    byte_t kb_ch;
    logic  kb_tr;
    logic  kb_hit;
    byte_t bank;
    byte_t cursor_x;
    byte_t cursor_y;

    word_t       prog [0:PROG_LEN-1];
    int          wp;
    int          kb_mark;      // Directed IN from KB_STAT
    logic [31:0] rng_state;

    // Reference model state
    byte_t m_regs [0:31];
    byte_t m_sreg;
    byte_t m_bank;
    byte_t m_cx;
    byte_t m_cy;
    word_t m_pc;
    logic  m_trig;
    int    m_cyc;              // Edges since reset release

    int reset_cycles;
    int run_cycles;
    int at_end;

    avr_core u_avr_core (
        .clock(clock), .rst_n(rst_n), .pc(pc), .ir(ir), .kb_ch(kb_ch), .kb_tr(kb_tr),
        .kb_hit(kb_hit), .bank(bank), .cursor_x(cursor_x), .cursor_y(cursor_y)
    );

    always #10 clock = ~clock;

    // ----------------------------------------
    // Random numbers and encoders
    // ----------------------------------------
    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return {16'h0000, rng_state[30:15]};
    endfunction

    function automatic int rand_below(input int n);
        return int'(lcg_next() % 32'(n));
    endfunction

    function automatic reg_idx_t rand_reg();
        return reg_idx_t'(rand_below(32));
    endfunction

    function automatic word_t enc_rr(input logic [5:0] code, input reg_idx_t d, input reg_idx_t r);
        return {code, r[4], d, r[3:0]};
    endfunction

    function automatic word_t enc_imm(input logic [3:0] code, input reg_idx_t d, input byte_t k);
        return {code, k[7:4], d[3:0], k[3:0]};  // d must be 16..31
    endfunction

    function automatic word_t enc_one(input reg_idx_t d, input logic [3:0] x);
        return {7'b1001010, d, x};
    endfunction

    function automatic word_t enc_in(input reg_idx_t d, input io_addr_t a);
        return {5'b10110, a[5:4], d, a[3:0]};
    endfunction

    function automatic word_t enc_out(input io_addr_t a, input reg_idx_t r);
        return {5'b10111, a[5:4], r, a[3:0]};
    endfunction

    function automatic word_t enc_branch(input logic clear, input logic [6:0] k,
                                         input logic [2:0] s);
        return {5'b11110, clear, k, s};
    endfunction

    task automatic put(input word_t w);
        prog[wp] = w;
        wp++;
    endtask

    // ----------------------------------------
    // Program generation
    // ----------------------------------------
    task automatic build_program();
        int sel;
        for (int i = 0; i < RAND_END; i++) begin
            sel = rand_below(16);
            if (i % 8 == 7)
                prog[i] = enc_out(rand_below(2) == 0 ? IO_CURSOR_X : IO_CURSOR_Y, rand_reg());
            else if (sel < 2)
                prog[i] = enc_imm(4'hE, rand_reg() | 5'h10, byte_t'(lcg_next()));
            else if (sel < 5 || sel == 15)
                prog[i] = enc_rr(RR_CODES[rand_below(10)], rand_reg(), rand_reg());
            else if (sel < 7)
                prog[i] = enc_imm(4'(3 + rand_below(5)), rand_reg() | 5'h10,
                                  byte_t'(lcg_next()));
            else if (sel < 9)
                prog[i] = enc_one(rand_reg(), ONE_CODES[rand_below(8)]);
            else if (sel < 11 && i < RAND_END - 8)  // Forward only, stays in random code
                prog[i] = enc_branch(1'(rand_below(2)), 7'(rand_below(6)), 3'(rand_below(8)));
            else if (sel == 11 && i < RAND_END - 8)
                prog[i] = {4'hC, 12'(rand_below(4))};
            else if (sel == 12)
                prog[i] = enc_in(rand_reg(), IN_ADDRS[rand_below(7)]);
            else if (sel == 13)
                prog[i] = enc_out(rand_below(2) == 0 ? IO_BANK : IO_SREG, rand_reg());
            else if (sel == 14)
                prog[i] = 16'h0000;
            else
                prog[i] = enc_imm(4'hE, rand_reg() | 5'h10, byte_t'(lcg_next()));
        end
        wp = RAND_END;
        // Z chaining of SBC, then of CPC
        put(enc_imm(4'hE, 16, 8'h10));
        put(enc_imm(4'hE, 17, 8'h10));
        put(enc_rr(6'b000110, 16, 17));    // SUB sets Z
        put(enc_imm(4'hE, 18, 8'h00));
        put(enc_imm(4'hE, 19, 8'h00));
        put(enc_rr(6'b000010, 18, 19));    // SBC keeps Z
        put(enc_in(20, IO_SREG));
        put(enc_out(IO_CURSOR_X, 20));
        put(enc_imm(4'hE, 16, 8'h01));
        put(enc_imm(4'hE, 17, 8'h00));
        put(enc_rr(6'b000101, 16, 17));    // CP clears Z
        put(enc_rr(6'b000001, 18, 19));    // CPC must not set it
        put(enc_in(20, IO_SREG));
        put(enc_out(IO_CURSOR_Y, 20));
        // Bank and keyboard
        put(enc_imm(4'hE, 16, 8'hA5));
        put(enc_out(IO_BANK, 16));
        put(enc_in(20, IO_KB_DATA));
        put(enc_out(IO_CURSOR_X, 20));
        kb_mark = wp;
        put(enc_in(21, IO_KB_STAT));
        put(enc_out(IO_CURSOR_Y, 21));
        put(enc_in(21, IO_KB_STAT));
        put(enc_out(IO_CURSOR_Y, 21));
        // About 103000 cycles of nested DEC loops, then read the timer
        put(enc_imm(4'hE, 25, 8'd200));
        put(enc_imm(4'hE, 24, 8'd0));
        put(enc_one(24, 4'hA));
        put(enc_branch(1'b1, 7'h7E, 3'd1)); // BRNE back to inner DEC
        put(enc_one(25, 4'hA));
        put(enc_branch(1'b1, 7'h7B, 3'd1)); // BRNE back to LDI r24
        put(enc_in(20, IO_TIMER_LO));
        put(enc_out(IO_CURSOR_X, 20));
        put(enc_in(21, IO_TIMER_HI));
        put(enc_out(IO_CURSOR_Y, 21));
        while (wp < END_PC)
            put(16'h0000);
        prog[END_PC] = {4'hC, 12'hFFF};    // RJMP to itself
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    task automatic compute_alu(input alu_op_t op, input byte_t a, input byte_t b,
                               input byte_t s, output byte_t r, output byte_t s_out);
        int   total;
        int   cin;
        logic c;
        logic v;
        logic upd;
        logic chain;
        cin   = (op == ALU_ADC || op == ALU_SBC) ? int'(s[FLAG_C]) : 0;
        c     = s[FLAG_C];
        v     = s[FLAG_V];
        upd   = 1'b1;
        chain = (op == ALU_SBC);
        r     = b;
        case (op)
            ALU_ADD, ALU_ADC: begin
                total = int'(a) + int'(b) + cin;
                r = 8'(total);
                c = (total > 255);
                v = (a[7] == b[7]) && (r[7] != a[7]);
            end
            ALU_SUB, ALU_SBC: begin
                total = int'(a) - int'(b) - cin;
                r = 8'(total);
                c = (total < 0);               // Borrow
                v = (a[7] != b[7]) && (r[7] != a[7]);
            end
            ALU_AND: begin r = a & b; v = 1'b0; end
            ALU_OR:  begin r = a | b; v = 1'b0; end
            ALU_EOR: begin r = a ^ b; v = 1'b0; end
            ALU_COM: begin r = ~a; c = 1'b1; v = 1'b0; end
            ALU_NEG: begin r = 8'(0 - int'(a)); c = (r != 0); v = (r == 8'h80); end
            ALU_INC: begin r = 8'(int'(a) + 1); v = (r == 8'h80); end
            ALU_DEC: begin r = 8'(int'(a) - 1); v = (r == 8'h7F); end
            ALU_ASR: begin r = {a[7], a[7:1]}; c = a[0]; v = r[7] ^ a[0]; end
            ALU_LSR: begin r = {1'b0, a[7:1]}; c = a[0]; v = a[0]; end
            ALU_ROR: begin r = {s[FLAG_C], a[7:1]}; c = a[0]; v = r[7] ^ a[0]; end
            ALU_SWAP: begin r = {a[3:0], a[7:4]}; upd = 1'b0; end
            default: upd = 1'b0;
        endcase
        s_out = s;
        if (upd) begin
            s_out[FLAG_C] = c;
            s_out[FLAG_Z] = (r == 8'h00) && (!chain || s[FLAG_Z]);
            s_out[FLAG_N] = r[7];
            s_out[FLAG_V] = v;
            s_out[FLAG_S] = r[7] ^ v;
        end
    endtask

    function automatic byte_t io_read(input io_addr_t a);
        logic [15:0] ms;
        ms = 16'(m_cyc / TIMER_DIV);
        case (a)
            IO_BANK:     return m_bank;
            IO_KB_DATA:  return kb_ch;
            IO_KB_STAT:  return {7'b0, m_trig ^ kb_tr};
            IO_CURSOR_X: return m_cx;
            IO_CURSOR_Y: return m_cy;
            IO_TIMER_LO: return ms[7:0];
            IO_TIMER_HI: return ms[15:8];
            IO_SREG:     return m_sreg;
            default:     return 8'h00;
        endcase
    endfunction

    task automatic io_write(input io_addr_t a, input byte_t v);
        case (a)
            IO_BANK:     m_bank = v;
            IO_CURSOR_X: m_cx = v;
            IO_CURSOR_Y: m_cy = v;
            IO_SREG:     m_sreg = v;
            default: ;
        endcase
    endtask

    task automatic model_step(input word_t w);
        byte_t    r;
        byte_t    s_new;
        reg_idx_t d;
        io_addr_t a;
        word_t    next_pc;
        alu_op_t  op;
        logic     wb;
        logic     fl;
        next_pc = m_pc + 16'd1;
        d       = w[8:4];
        a       = {w[10:9], w[3:0]};
        r       = 8'h00;
        s_new   = m_sreg;
        op      = ALU_PASS;
        wb      = 1'b0;
        fl      = 1'b0;
        case (w[15:12])
            4'h0, 4'h1, 4'h2: begin
                wb = 1'b1;
                fl = 1'b1;
                case (w[15:10])
                    6'b000011: op = ALU_ADD;
                    6'b000111: op = ALU_ADC;
                    6'b000110: op = ALU_SUB;
                    6'b000010: op = ALU_SBC;
                    6'b000101: begin op = ALU_SUB; wb = 1'b0; end  // CP
                    6'b000001: begin op = ALU_SBC; wb = 1'b0; end  // CPC
                    6'b001000: op = ALU_AND;
                    6'b001001: op = ALU_EOR;
                    6'b001010: op = ALU_OR;
                    6'b001011: fl = 1'b0;                         // MOV
                    default: begin wb = 1'b0; fl = 1'b0; end
                endcase
                compute_alu(op, m_regs[d], m_regs[{w[9], w[3:0]}], m_sreg, r, s_new);
            end
            4'h3, 4'h4, 4'h5, 4'h6, 4'h7: begin
                d  = {1'b1, w[7:4]};
                wb = (w[15:12] != 4'h3);   // CPI only sets flags
                fl = 1'b1;
                case (w[15:12])
                    4'h4:    op = ALU_SBC;
                    4'h6:    op = ALU_OR;
                    4'h7:    op = ALU_AND;
                    default: op = ALU_SUB;
                endcase
                compute_alu(op, m_regs[d], {w[11:8], w[3:0]}, m_sreg, r, s_new);
            end
            4'hE: begin
                d  = {1'b1, w[7:4]};
                wb = 1'b1;
                r  = {w[11:8], w[3:0]};
            end
            4'h9: if (w[11:9] == 3'b010) begin
                wb = 1'b1;
                fl = 1'b1;
                case (w[3:0])
                    4'h0: op = ALU_COM;
                    4'h1: op = ALU_NEG;
                    4'h2: op = ALU_SWAP;
                    4'h3: op = ALU_INC;
                    4'h5: op = ALU_ASR;
                    4'h6: op = ALU_LSR;
                    4'h7: op = ALU_ROR;
                    4'hA: op = ALU_DEC;
                    default: begin wb = 1'b0; fl = 1'b0; end
                endcase
                compute_alu(op, m_regs[d], 8'h00, m_sreg, r, s_new);
            end
            4'hB: if (!w[11]) begin
                wb = 1'b1;
                r  = io_read(a);
                if (a == IO_KB_STAT && r[0])
                    m_trig = ~m_trig;      // Hit acknowledged
            end else begin
                io_write(a, m_regs[d]);
            end
            4'hC: next_pc = next_pc + {{4{w[11]}}, w[11:0]};
            4'hF: if (!w[11] && (m_sreg[w[2:0]] != w[10]))
                next_pc = next_pc + {{9{w[9]}}, w[9:3]};
            default: ;
        endcase
        if (wb)
            m_regs[d] = r;
        if (fl)
            m_sreg = s_new;
        m_pc = next_pc;
        m_cyc++;
    endtask

    // ----------------------------------------
    // Checks and stimulus
    // ----------------------------------------
    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h at cycle %0d", name, got, exp, m_cyc);
            $display("TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h at cycle %0d", name, got, exp, m_cyc);
            $display("TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h at cycle %0d", name, got, exp, m_cyc);
            $display("TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_outputs();
        check_word("pc", pc, m_pc);
        check_byte("bank", bank, m_bank);
        check_byte("cursor_x", cursor_x, m_cx);
        check_byte("cursor_y", cursor_y, m_cy);
        check_bit("kb_hit", kb_hit, m_trig ^ kb_tr);
    endtask

    // Called on the falling edge, models the next rising edge
    task automatic drive_and_step();
        kb_ch = byte_t'(lcg_next());
        if (pc == word_t'(kb_mark))
            kb_tr = ~m_trig;               // Make sure the hit is up here
        else if (rand_below(16) == 0)
            kb_tr = ~kb_tr;
        ir = prog[pc];
        model_step(ir);
    endtask

    initial begin
        clock     = 1'b0;
        rst_n     = 1'b0;
        ir        = '0;
        kb_ch     = '0;
        kb_tr     = 1'b0;
        rng_state = 32'd68934;
        build_program();
        for (int i = 0; i < 32; i++)
            m_regs[i] = '0;
        m_sreg = '0;
        m_bank = '0;
        m_cx   = '0;
        m_cy   = '0;
        m_pc   = '0;
        m_trig = 1'b0;
        m_cyc  = 0;

        reset_cycles = 0;
        while (!(pc === 16'h0000 && bank === 8'h00 && cursor_x === 8'h00 &&
                 cursor_y === 8'h00)) begin
            @(negedge clock);
            reset_cycles++;
            if (reset_cycles > 8) begin
                $display("Timeout: DUT outputs did not clear while reset was held");
                $display("TESTS FAILED");
                $fatal(1, "reset timeout");
            end
        end
        while (reset_cycles < 8) begin
            @(negedge clock);
            reset_cycles++;
        end
        check_outputs();
        rst_n = 1'b1;
        drive_and_step();

        // Main run, stops after a few laps of the final RJMP
        run_cycles = 0;
        at_end     = 0;
        while (at_end < 4) begin
            @(negedge clock);
            check_outputs();
            run_cycles++;
            if (m_pc == word_t'(END_PC))
                at_end++;
            if (run_cycles > MAX_RUN) begin
                $display("Timeout: program did not reach its final jump");
                $display("TESTS FAILED");
                $fatal(1, "run timeout");
            end
            drive_and_step();
        end

        if (m_cyc <= 50000) begin
            $display("Run was too short to exercise the millisecond timer");
            $display("TESTS FAILED");
            $fatal(1, "short run");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

//--- avr_core.sv
module avr_core (
    input  logic           clock,
    input  logic           rst_n,
    output avr_pkg::word_t pc,
    input  avr_pkg::word_t ir,
    input  avr_pkg::byte_t kb_ch,
    input  logic           kb_tr,
    output logic           kb_hit,
    output avr_pkg::byte_t bank,
    output avr_pkg::byte_t cursor_x,
    output avr_pkg::byte_t cursor_y
);

    import avr_pkg::*;

    // Register file
    reg_idx_t rd_idx;
    reg_idx_t rr_idx;
    byte_t    rd_data;
    byte_t    rr_data;
    logic     reg_we;
    reg_idx_t reg_w_idx;
    byte_t    reg_w_data;

    // ALU
    alu_op_t  alu_op;
    byte_t    alu_a;
    byte_t    alu_b;
    byte_t    alu_result;
    byte_t    alu_flags;

    // I/O space
    byte_t    sreg;
    logic     flags_we;
    io_addr_t io_addr;
    logic     io_we;
    logic     io_re;
    byte_t    io_wdata;
    byte_t    io_rdata;

    sequencer u_sequencer (
        .clock(clock), .rst_n(rst_n), .pc(pc), .ir(ir),
        .rd_idx(rd_idx), .rr_idx(rr_idx), .rd_data(rd_data), .rr_data(rr_data),
        .reg_we(reg_we), .reg_w_idx(reg_w_idx), .reg_w_data(reg_w_data),
        .alu_op(alu_op), .alu_a(alu_a), .alu_b(alu_b),
        .alu_result(alu_result), .alu_flags(alu_flags), .sreg(sreg),
        .flags_we(flags_we), .io_addr(io_addr), .io_we(io_we), .io_re(io_re),
        .io_wdata(io_wdata), .io_rdata(io_rdata)
    );

    reg_file u_reg_file (
        .clock(clock), .rst_n(rst_n),
        .rd_idx(rd_idx), .rr_idx(rr_idx), .rd_data(rd_data), .rr_data(rr_data),
        .we(reg_we), .w_idx(reg_w_idx), .w_data(reg_w_data)
    );

    alu u_alu (
        .op(alu_op), .a(alu_a), .b(alu_b), .sreg(sreg),
        .result(alu_result), .flags(alu_flags)
    );

    io_space u_io_space (
        .clock(clock), .rst_n(rst_n), .addr(io_addr), .we(io_we), .re(io_re),
        .wdata(io_wdata), .rdata(io_rdata), .flags_we(flags_we), .flags(alu_flags),
        .sreg(sreg), .kb_ch(kb_ch), .kb_tr(kb_tr), .kb_hit(kb_hit),
        .bank(bank), .cursor_x(cursor_x), .cursor_y(cursor_y)
    );

endmodule

//--- sequencer.sv
module sequencer (
    input  logic              clock,
    input  logic              rst_n,
    output avr_pkg::word_t    pc,
    input  avr_pkg::word_t    ir,
    output avr_pkg::reg_idx_t rd_idx,
    output avr_pkg::reg_idx_t rr_idx,
    input  avr_pkg::byte_t    rd_data,
    input  avr_pkg::byte_t    rr_data,
    output logic              reg_we,
    output avr_pkg::reg_idx_t reg_w_idx,
    output avr_pkg::byte_t    reg_w_data,
    output avr_pkg::alu_op_t  alu_op,
    output avr_pkg::byte_t    alu_a,
    output avr_pkg::byte_t    alu_b,
    input  avr_pkg::byte_t    alu_result,
    input  avr_pkg::byte_t    alu_flags,
    input  avr_pkg::byte_t    sreg,
    output logic              flags_we,
    output avr_pkg::io_addr_t io_addr,
    output logic              io_we,
    output logic              io_re,
    output avr_pkg::byte_t    io_wdata,
    input  avr_pkg::byte_t    io_rdata
);

    import avr_pkg::*;

    instr_kind_t kind;
    alu_op_t     dec_op;
    logic        no_wb;     // Compare sets flags only
    logic        imm_form;  // Rd is 16..31 and b is K
    logic        taken;
    reg_idx_t    dst;
    word_t       pc_inc;
    word_t       pc_next;

    // ----------------------------------------
    // Decode
    // ----------------------------------------
    always_comb begin
        kind   = KIND_NOP;
        dec_op = ALU_PASS;
        no_wb  = 1'b0;
        casez (ir)
            16'b0000_01??_????_????: begin kind = KIND_ALU_RR; dec_op = ALU_SBC; no_wb = 1'b1; end
            16'b0000_10??_????_????: begin kind = KIND_ALU_RR; dec_op = ALU_SBC; end
            16'b0000_11??_????_????: begin kind = KIND_ALU_RR; dec_op = ALU_ADD; end
            16'b0001_01??_????_????: begin kind = KIND_ALU_RR; dec_op = ALU_SUB; no_wb = 1'b1; end
            16'b0001_10??_????_????: begin kind = KIND_ALU_RR; dec_op = ALU_SUB; end
            16'b0001_11??_????_????: begin kind = KIND_ALU_RR; dec_op = ALU_ADC; end
            16'b0010_00??_????_????: begin kind = KIND_ALU_RR; dec_op = ALU_AND; end
            16'b0010_01??_????_????: begin kind = KIND_ALU_RR; dec_op = ALU_EOR; end
            16'b0010_10??_????_????: begin kind = KIND_ALU_RR; dec_op = ALU_OR;  end
            16'b0010_11??_????_????: kind = KIND_MOV;
            16'b0011_????_????_????: begin kind = KIND_ALU_IMM; dec_op = ALU_SUB; no_wb = 1'b1; end
            16'b0100_????_????_????: begin kind = KIND_ALU_IMM; dec_op = ALU_SBC; end
            16'b0101_????_????_????: begin kind = KIND_ALU_IMM; dec_op = ALU_SUB; end
            16'b0110_????_????_????: begin kind = KIND_ALU_IMM; dec_op = ALU_OR;  end
            16'b0111_????_????_????: begin kind = KIND_ALU_IMM; dec_op = ALU_AND; end
            16'b1001_010?_????_????: begin
                kind = KIND_ALU_ONE;
                case (ir[3:0])
                    4'h0:    dec_op = ALU_COM;
                    4'h1:    dec_op = ALU_NEG;
                    4'h2:    dec_op = ALU_SWAP;
                    4'h3:    dec_op = ALU_INC;
                    4'h5:    dec_op = ALU_ASR;
                    4'h6:    dec_op = ALU_LSR;
                    4'h7:    dec_op = ALU_ROR;
                    4'hA:    dec_op = ALU_DEC;
                    default: kind   = KIND_NOP;  // Jumps, bit ops and the like
                endcase
            end
            16'b1011_0???_????_????: kind = KIND_IN;
            16'b1011_1???_????_????: kind = KIND_OUT;
            16'b1100_????_????_????: kind = KIND_RJMP;
            16'b1110_????_????_????: kind = KIND_LDI;
            16'b1111_0???_????_????: kind = KIND_BRANCH;
            default:                 kind = KIND_NOP;
        endcase
    end

    // ----------------------------------------
    // Operands and writeback
    // ----------------------------------------
    assign imm_form = (kind == KIND_ALU_IMM) || (kind == KIND_LDI);
    assign dst      = imm_form ? {1'b1, ir[7:4]} : ir[8:4];

    assign rd_idx = dst;
    assign rr_idx = {ir[9], ir[3:0]};
    assign alu_op = dec_op;
    assign alu_a  = rd_data;
    assign alu_b  = imm_form ? {ir[11:8], ir[3:0]} : rr_data;  // K or Rr

    assign reg_we = !no_wb && (kind == KIND_LDI || kind == KIND_MOV ||
                               kind == KIND_ALU_RR || kind == KIND_ALU_IMM ||
                               kind == KIND_ALU_ONE || kind == KIND_IN);
    assign reg_w_idx  = dst;
    assign reg_w_data = (kind == KIND_IN) ? io_rdata : alu_result;

    // All ALU classes load SREG, SWAP hands back the old flags
    assign flags_we = (kind == KIND_ALU_RR) || (kind == KIND_ALU_IMM) ||
                      (kind == KIND_ALU_ONE);

    assign io_addr  = {ir[10:9], ir[3:0]};
    assign io_wdata = rd_data;
    assign io_we    = (kind == KIND_OUT);
    assign io_re    = (kind == KIND_IN);

    // ----------------------------------------
    // Program counter
    // ----------------------------------------
    assign taken  = sreg[ir[2:0]] ^ ir[10];  // BRBS when bit 10 is 0
    assign pc_inc = pc + 16'd1;

    always_comb begin
        pc_next = pc_inc;
        if (kind == KIND_RJMP)
            pc_next = pc_inc + {{4{ir[11]}}, ir[11:0]};
        else if (kind == KIND_BRANCH && taken)
            pc_next = pc_inc + {{9{ir[9]}}, ir[9:3]};
    end

    always_ff @(posedge clock) begin
        if (!rst_n)
            pc <= '0;
        else
            pc <= pc_next;
    end

endmodule

//--- reg_file.sv
module reg_file (
    input  logic              clock,
    input  logic              rst_n,
    input  avr_pkg::reg_idx_t rd_idx,
    input  avr_pkg::reg_idx_t rr_idx,
    output avr_pkg::byte_t    rd_data,
    output avr_pkg::byte_t    rr_data,
    input  logic              we,
    input  avr_pkg::reg_idx_t w_idx,
    input  avr_pkg::byte_t    w_data
);

    import avr_pkg::*;

    byte_t regs [0:31];  // R0..R31

    // Two asynchronous read ports
    assign rd_data = regs[rd_idx];
    assign rr_data = regs[rr_idx];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we) begin
            regs[w_idx] <= w_data;
        end
    end

endmodule

//--- io_space.sv
module io_space (
    input  logic              clock,
    input  logic              rst_n,
    input  avr_pkg::io_addr_t addr,
    input  logic              we,
    input  logic              re,
    input  avr_pkg::byte_t    wdata,
    output avr_pkg::byte_t    rdata,
    input  logic              flags_we,
    input  avr_pkg::byte_t    flags,      // From the ALU
    output avr_pkg::byte_t    sreg,
    input  avr_pkg::byte_t    kb_ch,
    input  logic              kb_tr,
    output logic              kb_hit,
    output avr_pkg::byte_t    bank,
    output avr_pkg::byte_t    cursor_x,
    output avr_pkg::byte_t    cursor_y
);

    import avr_pkg::*;

    logic                   kb_trigger;
    logic [TIMER_DIV_W-1:0] timer_div;
    logic [15:0]            timer_ms;

    assign kb_hit = kb_trigger ^ kb_tr;  // Hit while the two differ

    // ----------------------------------------
    // Read multiplexer
    // ----------------------------------------
    always_comb begin
        case (addr)
            IO_BANK:     rdata = bank;
            IO_KB_DATA:  rdata = kb_ch;
            IO_KB_STAT:  rdata = {7'b0, kb_hit};
            IO_CURSOR_X: rdata = cursor_x;
            IO_CURSOR_Y: rdata = cursor_y;
            IO_TIMER_LO: rdata = timer_ms[7:0];
            IO_TIMER_HI: rdata = timer_ms[15:8];
            IO_SREG:     rdata = sreg;
            default:     rdata = 8'h00;
        endcase
    end

    // Registers written by OUT
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            bank       <= '0;
            cursor_x   <= '0;
            cursor_y   <= '0;
            sreg       <= '0;
            kb_trigger <= 1'b0;
        end else begin
            if (we && addr == IO_BANK)     bank     <= wdata;
            if (we && addr == IO_CURSOR_X) cursor_x <= wdata;
            if (we && addr == IO_CURSOR_Y) cursor_y <= wdata;

            // OUT to SREG wins over the ALU flags
            if (we && addr == IO_SREG)
                sreg <= wdata;
            else if (flags_we)
                sreg <= flags;

            // Reading the hit acknowledges it
            if (re && addr == IO_KB_STAT && kb_hit)
                kb_trigger <= ~kb_trigger;
        end
    end

    // Millisecond timer
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            timer_div <= '0;
            timer_ms  <= '0;
        end else if (timer_div == TIMER_DIV_W'(TIMER_DIV - 1)) begin
            timer_div <= '0;
            timer_ms  <= timer_ms + 16'd1;
        end else begin
            timer_div <= timer_div + 1'b1;
        end
    end

endmodule

//--- alu.sv
module alu (
    input  avr_pkg::alu_op_t op,
    input  avr_pkg::byte_t   a,       // Rd
    input  avr_pkg::byte_t   b,       // Rr or K
    input  avr_pkg::byte_t   sreg,
    output avr_pkg::byte_t   result,
    output avr_pkg::byte_t   flags
);

    import avr_pkg::*;

    logic [8:0] wide;     // Sum or difference with carry bit
    logic       c;
    logic       v;
    logic       z;
    logic       nz_upd;   // Flags recomputed by this op
    logic       z_chain;  // SBC/CPC keep Z only if already set

    // ----------------------------------------
    // Result, carry and overflow
    // ----------------------------------------
    always_comb begin
        wide    = '0;
        result  = b;
        c       = sreg[FLAG_C];
        v       = sreg[FLAG_V];
        nz_upd  = 1'b1;
        z_chain = 1'b0;

        case (op)
            ALU_ADD, ALU_ADC: begin
                wide   = {1'b0, a} + {1'b0, b};
                if (op == ALU_ADC)
                    wide = wide + {8'h00, sreg[FLAG_C]};
                result = wide[7:0];
                c      = wide[8];
                v      = (a[7] & b[7] & ~result[7]) | (~a[7] & ~b[7] & result[7]);
            end
            ALU_SUB, ALU_SBC: begin
                wide    = {1'b0, a} - {1'b0, b};
                if (op == ALU_SBC)
                    wide = wide - {8'h00, sreg[FLAG_C]};
                result  = wide[7:0];
                c       = wide[8];             // Borrow
                v       = (a[7] & ~b[7] & ~result[7]) | (~a[7] & b[7] & result[7]);
                z_chain = (op == ALU_SBC);
            end
            ALU_AND: begin result = a & b; v = 1'b0; end
            ALU_OR:  begin result = a | b; v = 1'b0; end
            ALU_EOR: begin result = a ^ b; v = 1'b0; end
            ALU_COM: begin
                result = ~a;
                c      = 1'b1;
                v      = 1'b0;
            end
            ALU_NEG: begin
                result = 8'h00 - a;
                c      = (result != 8'h00);
                v      = (result == 8'h80);
            end
            ALU_INC: begin result = a + 8'h01; v = (result == 8'h80); end
            ALU_DEC: begin result = a - 8'h01; v = (result == 8'h7F); end
            ALU_ASR, ALU_LSR, ALU_ROR: begin
                case (op)
                    ALU_ASR: result = {a[7], a[7:1]};
                    ALU_LSR: result = {1'b0, a[7:1]};  // N ends up 0
                    default: result = {sreg[FLAG_C], a[7:1]};
                endcase
                c = a[0];
                v = result[7] ^ a[0];
            end
            ALU_SWAP: begin
                result = {a[3:0], a[7:4]};
                nz_upd = 1'b0;
            end
            default: nz_upd = 1'b0;            // PASS
        endcase
    end

    // New SREG, bits 5..7 untouched
    always_comb begin
        flags = sreg;
        z     = (result == 8'h00) && (!z_chain || sreg[FLAG_Z]);
        if (nz_upd) begin
            flags[FLAG_C] = c;
            flags[FLAG_Z] = z;
            flags[FLAG_N] = result[7];
            flags[FLAG_V] = v;
            flags[FLAG_S] = result[7] ^ v;
        end
    end

endmodule

//--- avr_pkg.sv
package avr_pkg;

    // ----------------------------------------
    // Basic data types
    // ----------------------------------------
    typedef logic [7:0]  byte_t;     // Register and I/O data
    typedef logic [15:0] word_t;     // Program address or instruction
    typedef logic [4:0]  reg_idx_t;  // R0..R31
    typedef logic [5:0]  io_addr_t;  // IN/OUT "A" field

    // ALU operations
    typedef enum logic [3:0] {
        ALU_PASS,
        ALU_ADD,
        ALU_ADC,
        ALU_SUB,
        ALU_SBC,
        ALU_AND,
        ALU_OR,
        ALU_EOR,
        ALU_COM,
        ALU_NEG,
        ALU_SWAP,
        ALU_INC,
        ALU_DEC,
        ALU_ASR,
        ALU_LSR,
        ALU_ROR
    } alu_op_t;

    // Decoded instruction classes
    typedef enum logic [3:0] {
        KIND_NOP,
        KIND_LDI,
        KIND_MOV,
        KIND_ALU_RR,   // Rd, Rr forms
        KIND_ALU_IMM,  // Rd (16..31), K forms
        KIND_ALU_ONE,  // Single operand
        KIND_RJMP,
        KIND_BRANCH,   // BRBS / BRBC
        KIND_IN,
        KIND_OUT
    } instr_kind_t;

    // ----------------------------------------
    // I/O map, A = data address - 0x20
    // ----------------------------------------
    localparam io_addr_t IO_BANK     = 6'h00;
    localparam io_addr_t IO_KB_DATA  = 6'h02;
    localparam io_addr_t IO_KB_STAT  = 6'h03;  // Bit 0 is the hit flag
    localparam io_addr_t IO_CURSOR_X = 6'h04;
    localparam io_addr_t IO_CURSOR_Y = 6'h05;
    localparam io_addr_t IO_TIMER_LO = 6'h06;
    localparam io_addr_t IO_TIMER_HI = 6'h07;
    localparam io_addr_t IO_SREG     = 6'h3F;

    // SREG bit positions
    localparam int FLAG_C = 0;
    localparam int FLAG_Z = 1;
    localparam int FLAG_N = 2;
    localparam int FLAG_V = 3;
    localparam int FLAG_S = 4;

    // 1 ms at 25 MHz
    localparam int TIMER_DIV   = 25000;
    localparam int TIMER_DIV_W = $clog2(TIMER_DIV);

endpackage
